// File: hdl/rvseed_pkg.sv
package rvseed_pkg;

    // core data and address width
    parameter int xlen = 64;
    parameter int axi_id_width = 4;

    // request operation from a core port
    typedef enum logic {
        req_read  = 1'b0,
        req_write = 1'b1
    } req_op_e;

    // axi burst and response encodings
    parameter logic [1:0] axi_burst_incr  = 2'b01;
    parameter logic [1:0] axi_resp_okay   = 2'b00;
    parameter logic [1:0] axi_resp_slverr = 2'b10;

    // ids stamped on read requests, one per requester
    parameter logic [axi_id_width-1:0] fetch_axi_id = 4'd0;
    parameter logic [axi_id_width-1:0] data_axi_id  = 4'd1;

    // request as presented by a core port
    typedef struct packed {
        logic            valid;
        req_op_e         op;
        logic [xlen-1:0] addr;
        logic [xlen-1:0] wdata;
        logic [7:0]      wstrb;
    } core_req_t;

    // arbiter to bridge, read side
    typedef struct packed {
        logic                    valid;
        logic [xlen-1:0]         addr;
        logic                    burst;
        logic [axi_id_width-1:0] id;
    } rd_req_t;

    // arbiter to bridge, write side
    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] addr;
        logic [xlen-1:0] wdata;
        logic [7:0]      wstrb;
    } wr_req_t;

    // axi channel payloads
    typedef struct packed {
        logic [xlen-1:0] addr;
    } axi_aw_t;

    typedef struct packed {
        logic [xlen-1:0] data;
        logic [7:0]      strb;
        logic            last;
    } axi_w_t;

    typedef struct packed {
        logic [xlen-1:0]         addr;
        logic [axi_id_width-1:0] id;
        logic [7:0]              len;
        logic [2:0]              size;
        logic [1:0]              burst;
    } axi_ar_t;

    typedef struct packed {
        logic [xlen-1:0]         data;
        logic [1:0]              resp;
        logic                    last;
        logic [axi_id_width-1:0] id;
    } axi_r_t;

endpackage

// File: hdl/mem_req_arbiter.sv
`timescale 1ns/10ps

module mem_req_arbiter
    import rvseed_pkg::*;
#(
    parameter int line_beats = 2
) (
    input  logic                       clock,
    input  logic                       reset,

    // core ports
    input  core_req_t                  fetch_req_i,
    input  core_req_t                  data_req_i,
    output logic                       fetch_done_o,
    output logic [line_beats*xlen-1:0] fetch_line_o,
    output logic                       fetch_err_o,
    output logic                       data_done_o,
    output logic [xlen-1:0]            data_rdata_o,
    output logic                       data_err_o,

    // bridge side
    output rd_req_t                    rd_req_o,
    output wr_req_t                    wr_req_o,
    input  logic                       rd_done_i,
    input  logic [line_beats*xlen-1:0] rd_line_i,
    input  logic                       rd_err_i,
    input  logic                       wr_done_i
);

    typedef enum logic {
        own_fetch,
        own_data
    } owner_e;

    // one request in flight per port
    logic    fetch_busy;
    logic    data_busy;
    owner_e  read_owner;
    rd_req_t rd_q;
    wr_req_t wr_q;

    // waiting requests
    logic fetch_rd_pend;
    logic data_rd_pend;
    logic data_wr_pend;
    logic rd_free;

    assign fetch_rd_pend = fetch_req_i.valid && !fetch_busy;
    assign data_rd_pend  = data_req_i.valid && !data_busy && (data_req_i.op == req_read);
    assign data_wr_pend  = data_req_i.valid && !data_busy && (data_req_i.op == req_write);
    assign rd_free       = !rd_q.valid;

    always_ff @(posedge clock) begin
        if (reset) begin
            fetch_busy  <= 1'b0;
            data_busy   <= 1'b0;
            read_owner  <= own_fetch;
            rd_q.valid  <= 1'b0;
            wr_q.valid  <= 1'b0;
        end else begin
            // write path, only the data port writes
            if (wr_done_i) begin
                wr_q.valid <= 1'b0;
                data_busy  <= 1'b0;
            end else if (data_wr_pend) begin
                wr_q.valid <= 1'b1;
                wr_q.addr  <= data_req_i.addr;
                wr_q.wdata <= data_req_i.wdata;
                wr_q.wstrb <= data_req_i.wstrb;
                data_busy  <= 1'b1;
            end

            // read channel release, frees the owning port
            if (rd_done_i) begin
                rd_q.valid <= 1'b0;
                if (read_owner == own_data) begin
                    data_busy <= 1'b0;
                end else begin
                    fetch_busy <= 1'b0;
                end
            end else if (rd_free) begin
                // fixed priority, data before fetch
                if (data_rd_pend) begin
                    rd_q.valid <= 1'b1;
                    rd_q.addr  <= data_req_i.addr;
                    rd_q.burst <= 1'b0;
                    rd_q.id    <= data_axi_id;
                    read_owner <= own_data;
                    data_busy  <= 1'b1;
                end else if (fetch_rd_pend) begin
                    rd_q.valid <= 1'b1;
                    rd_q.addr  <= fetch_req_i.addr;
                    rd_q.burst <= 1'b1;
                    rd_q.id    <= fetch_axi_id;
                    read_owner <= own_fetch;
                    fetch_busy <= 1'b1;
                end
            end
        end
    end

    assign rd_req_o = rd_q;
    assign wr_req_o = wr_q;

    // steer results back to whoever owns the read
    assign fetch_done_o = rd_done_i && (read_owner == own_fetch);
    assign fetch_line_o = rd_line_i;
    assign fetch_err_o  = rd_err_i && (read_owner == own_fetch);

    // data done covers both its reads and its writes
    assign data_done_o  = (rd_done_i && (read_owner == own_data)) || wr_done_i;
    // single beat reads sit in slot 0
    assign data_rdata_o = rd_line_i[xlen-1:0];
    assign data_err_o   = rd_err_i && (read_owner == own_data);

endmodule

// File: hdl/axi_bridge.sv
`timescale 1ns/10ps

module axi_bridge
    import rvseed_pkg::*;
#(
    parameter int line_beats = 2
) (
    input  logic                       clock,
    input  logic                       reset,

    // requests from the arbiter
    input  rd_req_t                    rd_req_i,
    input  wr_req_t                    wr_req_i,
    output logic                       rd_done_o,
    output logic [line_beats*xlen-1:0] rd_line_o,
    output logic                       rd_err_o,
    output logic                       wr_done_o,

    // axi write address
    output logic                       aw_valid_o,
    input  logic                       aw_ready_i,
    output axi_aw_t                    aw_o,

    // axi write data
    output logic                       w_valid_o,
    input  logic                       w_ready_i,
    output axi_w_t                     w_o,

    // axi write response
    input  logic                       b_valid_i,
    output logic                       b_ready_o,
    input  logic [1:0]                 b_resp_i,

    // axi read address
    output logic                       ar_valid_o,
    input  logic                       ar_ready_i,
    output axi_ar_t                    ar_o,

    // axi read data
    input  logic                       r_valid_i,
    output logic                       r_ready_o,
    input  axi_r_t                     r_i
);

    localparam int beat_w = $clog2(line_beats);

    typedef enum logic [1:0] {
        wr_idle,
        wr_addr,
        wr_data,
        wr_resp
    } wr_state_e;

    typedef enum logic [1:0] {
        rd_idle,
        rd_addr,
        rd_read
    } rd_state_e;

    wr_state_e wr_state;
    rd_state_e rd_state;

    // latched write payload
    axi_aw_t aw_q;
    axi_w_t  w_q;
    logic    wr_done_q;

    // latched read address and line assembly
    axi_ar_t                            ar_q;
    logic [line_beats-1:0][xlen-1:0]    line_q;
    logic [beat_w-1:0]                  beat_cnt;
    logic                               rd_err_q;
    logic                               rd_done_q;

    // handshakes
    logic aw_hs;
    logic w_hs;
    logic b_hs;
    logic ar_hs;
    logic r_hs;
    logic wr_accept;
    logic rd_accept;

    assign aw_hs = aw_valid_o && aw_ready_i;
    assign w_hs  = w_valid_o && w_ready_i;
    assign b_hs  = b_valid_i && b_ready_o;
    assign ar_hs = ar_valid_o && ar_ready_i;
    assign r_hs  = r_valid_i && r_ready_o;

    // request is still high during its own done cycle, so skip that one
    assign wr_accept = (wr_state == wr_idle) && wr_req_i.valid && !wr_done_q;
    assign rd_accept = (rd_state == rd_idle) && rd_req_i.valid && !rd_done_q;

    // write fsm: idle -> addr -> data -> resp
    always_ff @(posedge clock) begin
        if (reset) begin
            wr_state  <= wr_idle;
            wr_done_q <= 1'b0;
        end else begin
            wr_done_q <= 1'b0;
            case (wr_state)
                wr_idle: begin
                    if (wr_accept) begin
                        wr_state <= wr_addr;
                    end
                end
                wr_addr: begin
                    if (aw_hs) begin
                        wr_state <= wr_data;
                    end
                end
                wr_data: begin
                    if (w_hs) begin
                        wr_state <= wr_resp;
                    end
                end
                wr_resp: begin
                    // b response seen, done goes out next cycle
                    if (b_hs) begin
                        wr_state  <= wr_idle;
                        wr_done_q <= 1'b1;
                    end
                end
                default: wr_state <= wr_idle;
            endcase
        end
    end

    // write payload, captured once at acceptance
    always_ff @(posedge clock) begin
        if (wr_accept) begin
            aw_q.addr <= wr_req_i.addr;
            w_q.data  <= wr_req_i.wdata;
            w_q.strb  <= wr_req_i.wstrb;
            // single beat, so always last
            w_q.last  <= 1'b1;
        end
    end

    // read fsm: idle -> addr -> read
    always_ff @(posedge clock) begin
        if (reset) begin
            rd_state  <= rd_idle;
            rd_done_q <= 1'b0;
            rd_err_q  <= 1'b0;
            beat_cnt  <= '0;
        end else begin
            rd_done_q <= 1'b0;
            case (rd_state)
                rd_idle: begin
                    if (rd_accept) begin
                        rd_state <= rd_addr;
                        beat_cnt <= '0;
                        // new transaction, error starts clean
                        rd_err_q <= 1'b0;
                    end
                end
                rd_addr: begin
                    if (ar_hs) begin
                        rd_state <= rd_read;
                    end
                end
                rd_read: begin
                    if (r_hs) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        // sticky until the next accept
                        if (r_i.resp != axi_resp_okay) begin
                            rd_err_q <= 1'b1;
                        end
                        if (r_i.last) begin
                            rd_state  <= rd_idle;
                            rd_done_q <= 1'b1;
                        end
                    end
                end
                default: rd_state <= rd_idle;
            endcase
        end
    end

    // read address payload
    always_ff @(posedge clock) begin
        if (rd_accept) begin
            ar_q.addr  <= rd_req_i.addr;
            ar_q.id    <= rd_req_i.id;
            // line burst or a single beat
            ar_q.len   <= rd_req_i.burst ? 8'(line_beats - 1) : 8'd0;
            // 8 bytes per beat in both cases
            ar_q.size  <= 3'd3;
            ar_q.burst <= axi_burst_incr;
        end
    end

    // each beat lands in its own slot
    always_ff @(posedge clock) begin
        if (r_hs) begin
            line_q[beat_cnt] <= r_i.data;
        end
    end

    // axi outputs follow the states
    assign aw_valid_o = (wr_state == wr_addr);
    assign aw_o       = aw_q;
    assign w_valid_o  = (wr_state == wr_data);
    assign w_o        = w_q;
    assign b_ready_o  = (wr_state == wr_resp);

    assign ar_valid_o = (rd_state == rd_addr);
    assign ar_o       = ar_q;
    assign r_ready_o  = (rd_state == rd_read);

    // results back to the arbiter
    assign wr_done_o  = wr_done_q;
    assign rd_done_o  = rd_done_q;
    assign rd_line_o  = line_q;
    assign rd_err_o   = rd_err_q;

endmodule

// File: hdl/core_bus_top.sv
`timescale 1ns/10ps

module core_bus_top
    import rvseed_pkg::*;
#(
    parameter int line_beats = 2
) (
    input  logic                       clock,
    input  logic                       reset,

    // instruction fetch port
    input  core_req_t                  fetch_req_i,
    output logic                       fetch_done_o,
    output logic [line_beats*xlen-1:0] fetch_line_o,
    output logic                       fetch_err_o,

    // data port
    input  core_req_t                  data_req_i,
    output logic                       data_done_o,
    output logic [xlen-1:0]            data_rdata_o,
    output logic                       data_err_o,

    // axi4 master
    output logic                       aw_valid_o,
    input  logic                       aw_ready_i,
    output axi_aw_t                    aw_o,
    output logic                       w_valid_o,
    input  logic                       w_ready_i,
    output axi_w_t                     w_o,
    input  logic                       b_valid_i,
    output logic                       b_ready_o,
    input  logic [1:0]                 b_resp_i,
    output logic                       ar_valid_o,
    input  logic                       ar_ready_i,
    output axi_ar_t                    ar_o,
    input  logic                       r_valid_i,
    output logic                       r_ready_o,
    input  axi_r_t                     r_i
);

    // arbiter to bridge
    rd_req_t                    rd_req;
    wr_req_t                    wr_req;
    logic                       rd_done;
    logic [line_beats*xlen-1:0] rd_line;
    logic                       rd_err;
    logic                       wr_done;

    mem_req_arbiter #(
        .line_beats (line_beats)
    ) u_arbiter (
        .clock        (clock),
        .reset        (reset),
        .fetch_req_i  (fetch_req_i),
        .data_req_i   (data_req_i),
        .fetch_done_o (fetch_done_o),
        .fetch_line_o (fetch_line_o),
        .fetch_err_o  (fetch_err_o),
        .data_done_o  (data_done_o),
        .data_rdata_o (data_rdata_o),
        .data_err_o   (data_err_o),
        .rd_req_o     (rd_req),
        .wr_req_o     (wr_req),
        .rd_done_i    (rd_done),
        .rd_line_i    (rd_line),
        .rd_err_i     (rd_err),
        .wr_done_i    (wr_done)
    );

    // read and write run independently in here
    axi_bridge #(
        .line_beats (line_beats)
    ) u_bridge (
        .clock      (clock),
        .reset      (reset),
        .rd_req_i   (rd_req),
        .wr_req_i   (wr_req),
        .rd_done_o  (rd_done),
        .rd_line_o  (rd_line),
        .rd_err_o   (rd_err),
        .wr_done_o  (wr_done),
        .aw_valid_o (aw_valid_o),
        .aw_ready_i (aw_ready_i),
        .aw_o       (aw_o),
        .w_valid_o  (w_valid_o),
        .w_ready_i  (w_ready_i),
        .w_o        (w_o),
        .b_valid_i  (b_valid_i),
        .b_ready_o  (b_ready_o),
        .b_resp_i   (b_resp_i),
        .ar_valid_o (ar_valid_o),
        .ar_ready_i (ar_ready_i),
        .ar_o       (ar_o),
        .r_valid_i  (r_valid_i),
        .r_ready_o  (r_ready_o),
        .r_i        (r_i)
    );

endmodule

// File: testbench/tb_axi_mem_model.sv
`timescale 1ns/10ps

module tb_axi_mem_model
    import rvseed_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  logic       stall_en_i,

    // write side
    input  logic       aw_valid_i,
    output logic       aw_ready_o,
    input  axi_aw_t    aw_i,
    input  logic       w_valid_i,
    output logic       w_ready_o,
    input  axi_w_t     w_i,
    output logic       b_valid_o,
    input  logic       b_ready_i,
    output logic [1:0] b_resp_o,

    // read side
    input  logic       ar_valid_i,
    output logic       ar_ready_o,
    input  axi_ar_t    ar_i,
    output logic       r_valid_o,
    input  logic       r_ready_i,
    output axi_r_t     r_o
);

    // everything at or above this address answers slverr
    localparam logic [xlen-1:0] err_base = 64'h800;

    logic [xlen-1:0] mem [0:255];

    // one ready enable per channel: aw, w, ar
    logic [2:0] roll;

    logic            aw_pend;
    logic [xlen-1:0] aw_addr;
    logic            ar_pend;
    logic [xlen-1:0] rd_addr;
    logic [7:0]      rd_left;
    logic [3:0]      rd_id;

    always @(posedge clock) begin
        if (reset || !stall_en_i) begin
            roll <= 3'b111;
        end else begin
            roll <= 3'($urandom);
        end
    end

    assign aw_ready_o = !aw_pend && roll[0];
    // data only after its address, and not while b waits
    assign w_ready_o  = aw_pend && !b_valid_o && roll[1];
    assign ar_ready_o = !ar_pend && roll[2];

    // write channel and memory
    always @(posedge clock) begin
        if (reset) begin
            aw_pend   <= 1'b0;
            aw_addr   <= '0;
            b_valid_o <= 1'b0;
            b_resp_o  <= axi_resp_okay;
            // both halves hold index times the golden ratio constant
            for (int k = 0; k < 256; k++) begin
                mem[k] <= {2{32'(k) * 32'h9E3779B9}};
            end
        end else begin
            if (aw_valid_i && aw_ready_o) begin
                aw_pend <= 1'b1;
                aw_addr <= aw_i.addr;
            end
            if (w_valid_i && w_ready_o) begin
                aw_pend   <= 1'b0;
                b_valid_o <= 1'b1;
                if (aw_addr >= err_base) begin
                    b_resp_o <= axi_resp_slverr;
                end else begin
                    b_resp_o <= axi_resp_okay;
                    // byte merge under the strobes
                    for (int b = 0; b < 8; b++) begin
                        if (w_i.strb[b]) begin
                            mem[aw_addr[10:3]][b*8 +: 8] <= w_i.data[b*8 +: 8];
                        end
                    end
                end
            end else if (b_valid_o && b_ready_i) begin
                b_valid_o <= 1'b0;
            end
        end
    end

    // read channel, one beat per r handshake
    always @(posedge clock) begin
        if (reset) begin
            ar_pend   <= 1'b0;
            r_valid_o <= 1'b0;
            rd_addr   <= '0;
            rd_left   <= '0;
            rd_id     <= '0;
        end else begin
            if (ar_valid_i && ar_ready_o) begin
                ar_pend <= 1'b1;
                rd_addr <= ar_i.addr;
                rd_left <= ar_i.len;
                rd_id   <= ar_i.id;
            end
            if (r_valid_o && r_ready_i) begin
                r_valid_o <= 1'b0;
                if (rd_left == 8'd0) begin
                    ar_pend <= 1'b0;
                end else begin
                    rd_addr <= rd_addr + 64'd8;
                    rd_left <= rd_left - 8'd1;
                end
            end else if (ar_pend) begin
                r_valid_o <= 1'b1;
            end
        end
    end

    // payload only moves on a handshake, so it holds while valid
    always_comb begin
        r_o.data = (rd_addr >= err_base) ? '0 : mem[rd_addr[10:3]];
        r_o.resp = (rd_addr >= err_base) ? axi_resp_slverr : axi_resp_okay;
        r_o.last = (rd_left == 8'd0);
        r_o.id   = rd_id;
    end

endmodule

// File: testbench/tb_core_bus.sv
`timescale 1ns/10ps

module tb_core_bus
    import rvseed_pkg::*;
();

    localparam int line_beats = 2;
    localparam int cw = line_beats * xlen;
    // 5 requests unstalled, 5 stalled, 2 in the error test
    localparam int num_requests = 12;
    localparam int timeout_cycles = 20 * num_requests + 200;

    logic      clock;
    logic      reset;
    logic      stall_en;
    core_req_t fetch_req;
    core_req_t data_req;

    logic            fetch_done;
    logic [cw-1:0]   fetch_line;
    logic            fetch_err;
    logic            data_done;
    logic [xlen-1:0] data_rdata;
    logic            data_err;

    // axi between dut and slave model
    logic       aw_valid;
    logic       aw_ready;
    axi_aw_t    aw;
    logic       w_valid;
    logic       w_ready;
    axi_w_t     w;
    logic       b_valid;
    logic       b_ready;
    logic [1:0] b_resp;
    logic       ar_valid;
    logic       ar_ready;
    axi_ar_t    ar;
    logic       r_valid;
    logic       r_ready;
    axi_r_t     r;

    int cycle = 0;
    int checks = 0;
    int errors = 0;
    int test_errors = 0;

    core_bus_top #(
        .line_beats (line_beats)
    ) dut (
        .clock        (clock),
        .reset        (reset),
        .fetch_req_i  (fetch_req),
        .fetch_done_o (fetch_done),
        .fetch_line_o (fetch_line),
        .fetch_err_o  (fetch_err),
        .data_req_i   (data_req),
        .data_done_o  (data_done),
        .data_rdata_o (data_rdata),
        .data_err_o   (data_err),
        .aw_valid_o   (aw_valid),
        .aw_ready_i   (aw_ready),
        .aw_o         (aw),
        .w_valid_o    (w_valid),
        .w_ready_i    (w_ready),
        .w_o          (w),
        .b_valid_i    (b_valid),
        .b_ready_o    (b_ready),
        .b_resp_i     (b_resp),
        .ar_valid_o   (ar_valid),
        .ar_ready_i   (ar_ready),
        .ar_o         (ar),
        .r_valid_i    (r_valid),
        .r_ready_o    (r_ready),
        .r_i          (r)
    );

    tb_axi_mem_model slave (
        .clock      (clock),
        .reset      (reset),
        .stall_en_i (stall_en),
        .aw_valid_i (aw_valid),
        .aw_ready_o (aw_ready),
        .aw_i       (aw),
        .w_valid_i  (w_valid),
        .w_ready_o  (w_ready),
        .w_i        (w),
        .b_valid_o  (b_valid),
        .b_ready_i  (b_ready),
        .b_resp_o   (b_resp),
        .ar_valid_i (ar_valid),
        .ar_ready_o (ar_ready),
        .ar_i       (ar),
        .r_valid_o  (r_valid),
        .r_ready_i  (r_ready),
        .r_o        (r)
    );

    // 100 ns period
    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle <= cycle + 1;
    end

    // run limit
    initial begin
        wait (cycle >= timeout_cycles);
        $display("timeout: a done pulse did not arrive within %0d cycles", timeout_cycles);
        $display("Something failed");
        $finish;
    end

    // memory contents right after reset
    function automatic logic [xlen-1:0] initial_word(input int unsigned idx);
        logic [31:0] half;
        half = 32'(idx) * 32'h9E3779B9;
        return {half, half};
    endfunction

    function automatic logic [xlen-1:0] merge_bytes(input logic [xlen-1:0] old_word,
                                                    input logic [xlen-1:0] new_word,
                                                    input logic [7:0] strb);
        logic [xlen-1:0] result;
        result = old_word;
        for (int b = 0; b < 8; b++) begin
            if (strb[b]) begin
                result[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return result;
    endfunction

    // word i of the line comes from word index base+i
    function automatic logic [cw-1:0] expected_line(input int unsigned base_idx);
        logic [cw-1:0] line;
        for (int i = 0; i < line_beats; i++) begin
            line[i*xlen +: xlen] = initial_word(base_idx + i);
        end
        return line;
    endfunction

    task automatic check_value(input string what, input logic [cw-1:0] got,
                               input logic [cw-1:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            test_errors++;
            $display("[ERROR] %0t: %s, got %h, expected %h", $time, what, got, expected);
        end
    endtask

    task automatic report_test(input string name);
        if (test_errors == 0) begin
            $display("test %s: pass", name);
        end else begin
            $display("test %s: %0d mismatches", name, test_errors);
        end
        test_errors = 0;
    endtask

    // ar and w payload fields, a line burst carries the fetch id
    always @(posedge clock) begin
        if (!reset && ar_valid && ar_ready) begin
            if (ar.len == 8'(line_beats - 1)) begin
                check_value("ar id of a line fetch", cw'(ar.id), cw'(fetch_axi_id));
            end else begin
                check_value("ar len of a single read", cw'(ar.len), '0);
                check_value("ar id of a single read", cw'(ar.id), cw'(data_axi_id));
            end
            check_value("ar size", cw'(ar.size), cw'(3'd3));
            check_value("ar burst", cw'(ar.burst), cw'(axi_burst_incr));
        end
        if (!reset && w_valid && w_ready) begin
            check_value("w last", cw'(w.last), cw'(1'b1));
        end
    end

    task automatic drive_data(input req_op_e op, input logic [xlen-1:0] addr,
                              input logic [xlen-1:0] wdata, input logic [7:0] wstrb);
        data_req <= '{valid: 1'b1, op: op, addr: addr, wdata: wdata, wstrb: wstrb};
    endtask

    task automatic drive_fetch(input logic [xlen-1:0] addr);
        fetch_req <= '{valid: 1'b1, op: req_read, addr: addr, wdata: '0, wstrb: '0};
    endtask

    task automatic wait_data_done(output logic [xlen-1:0] rdata, output logic err,
                                  output int at_cycle);
        @(posedge clock);
        while (!data_done) begin
            @(posedge clock);
        end
        rdata = data_rdata;
        err = data_err;
        at_cycle = cycle;
        // valid drops in the cycle after done
        data_req.valid <= 1'b0;
    endtask

    task automatic wait_fetch_done(output logic [cw-1:0] line, output logic err,
                                   output int at_cycle);
        @(posedge clock);
        while (!fetch_done) begin
            @(posedge clock);
        end
        line = fetch_line;
        err = fetch_err;
        at_cycle = cycle;
        fetch_req.valid <= 1'b0;
    endtask

    task automatic data_access(input req_op_e op, input logic [xlen-1:0] addr,
                               input logic [xlen-1:0] wdata, input logic [7:0] wstrb,
                               output logic [xlen-1:0] rdata, output logic err);
        int done_at;
        @(posedge clock);
        drive_data(op, addr, wdata, wstrb);
        wait_data_done(rdata, err, done_at);
    endtask

    task automatic fetch_access(input logic [xlen-1:0] addr, output logic [cw-1:0] line,
                                output logic err);
        int done_at;
        @(posedge clock);
        drive_fetch(addr);
        wait_fetch_done(line, err, done_at);
    endtask

    task automatic test_idle_outputs();
        repeat (10) begin
            @(posedge clock);
            check_value("idle valid, ready and done",
                        cw'({aw_valid, w_valid, b_ready, ar_valid, r_ready,
                             fetch_done, data_done}), '0);
        end
        report_test("idle after reset");
    endtask

    // partial strobe write, then read back of the same word
    task automatic test_write_read(input string name, input logic [xlen-1:0] addr);
        logic [xlen-1:0] rdata;
        logic            err;
        logic [xlen-1:0] expected;
        data_access(req_write, addr, 64'hDEAD_BEEF_0BAD_F00D, 8'b1010_0110, rdata, err);
        check_value({name, ": write error flag"}, cw'(err), '0);
        data_access(req_read, addr, '0, '0, rdata, err);
        // word index is the byte address over 8
        expected = merge_bytes(initial_word(32'(addr >> 3)), 64'hDEAD_BEEF_0BAD_F00D,
                               8'b1010_0110);
        check_value({name, ": read data"}, cw'(rdata), cw'(expected));
        check_value({name, ": read error flag"}, cw'(err), '0);
        report_test(name);
    endtask

    task automatic test_fetch_line(input string name);
        logic [cw-1:0] line;
        logic          err;
        fetch_access(64'h200, line, err);
        check_value({name, ": line"}, line, expected_line(32'h40));
        check_value({name, ": error flag"}, cw'(err), '0);
        report_test(name);
    endtask

    // both ports raised in one cycle
    task automatic test_fetch_and_data(input string name);
        logic [cw-1:0]   line;
        logic            line_err;
        logic [xlen-1:0] rdata;
        logic            rdata_err;
        int              fetch_at;
        int              data_at;
        @(posedge clock);
        drive_fetch(64'h300);
        drive_data(req_read, 64'h3A8, '0, '0);
        fork
            wait_fetch_done(line, line_err, fetch_at);
            wait_data_done(rdata, rdata_err, data_at);
        join
        check_value({name, ": fetch line"}, line, expected_line(32'h60));
        check_value({name, ": fetch error flag"}, cw'(line_err), '0);
        check_value({name, ": data word"}, cw'(rdata), cw'(initial_word(32'h75)));
        check_value({name, ": data error flag"}, cw'(rdata_err), '0);
        // data port has priority on the read channel
        check_value({name, ": data done not after fetch done"},
                    cw'(data_at <= fetch_at), cw'(1'b1));
        report_test(name);
    endtask

    task automatic test_error_window(input string name);
        logic [xlen-1:0] rdata;
        logic [cw-1:0]   line;
        logic            err;
        data_access(req_read, 64'hA00, '0, '0, rdata, err);
        check_value({name, ": data error flag"}, cw'(err), cw'(1'b1));
        check_value({name, ": data word"}, cw'(rdata), '0);
        // error must not leak into the next read
        fetch_access(64'h040, line, err);
        check_value({name, ": fetch line"}, line, expected_line(32'h8));
        check_value({name, ": fetch error flag"}, cw'(err), '0);
        report_test(name);
    endtask

    initial begin
        void'($urandom(32'h639));
        reset = 1'b1;
        stall_en = 1'b0;
        fetch_req = '0;
        data_req = '0;
        repeat (5) @(posedge clock);
        reset <= 1'b0;

        test_idle_outputs();
        test_write_read("write then read", 64'h128);
        test_fetch_line("line fetch");
        test_fetch_and_data("fetch and data read together");

        // same tests with ready stalls in the slave
        @(posedge clock);
        stall_en <= 1'b1;
        // fresh word, so a lost write shows up
        test_write_read("write then read, stalled", 64'h1B0);
        test_fetch_line("line fetch, stalled");
        test_fetch_and_data("fetch and data read together, stalled");

        test_error_window("error window then clean fetch");

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: all.f
hdl/rvseed_pkg.sv
hdl/mem_req_arbiter.sv
hdl/axi_bridge.sv
hdl/core_bus_top.sv
testbench/tb_axi_mem_model.sv
testbench/tb_core_bus.sv

// File: Makefile
# Verilator build for the core bus testbench

VERILATOR ?= verilator
VFLAGS    ?= --timing -j 0
TOP       ?= tb_core_bus
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Everything OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# build, run, then decide pass or fail from the log
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation result: pass"; \
	else \
		echo "simulation result: fail, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
